/* mc_board_top.f */
+incdir+.
mc_bus_pkg.sv
mc_motor_pkg.sv
mc_reg_ctrl.sv
mc_watchdog.sv
mc_motor_bank.sv
mc_board_top.sv
mc_board_chk.sv
mc_board_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := mc_board_tb
FILELIST  := mc_board_top.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST)) mc_cfg.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* mc_board_tb.sv */
// testbench for the board top level, drives the wishbone port and checks registers, enables and watchdog
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_board_tb;

    import mc_bus_pkg::*;
    import mc_motor_pkg::*;

    localparam int bus_timeout = 20;                          // cycles allowed for an ack
    localparam int wdog_min    = 4 * `MC_WDOG_TICK_DIV;       // period 4, earliest rise
    localparam int wdog_max    = 5 * `MC_WDOG_TICK_DIV + 2;   // latest rise, prescaler phase

    logic                            sysclk;
    logic                            rst_n;
    board_id_t                       board_id;
    logic                            cyc;
    logic                            stb;
    logic                            we;
    wb_addr_t                        adr;
    wb_data_t                        dat_w;
    wb_data_t                        dat_r;
    logic                            ack;
    amp_mask_t                       amp_en;
    setpoint_t [`MC_NUM_MOTORS-1:0]  dac_code;
    logic                            wdog_timeout;
    logic [2:0]                      wdog_period_status;

    int        seed;
    int        err_cnt;
    int        timeout_cnt;
    int        cycle_cnt;               // free running, for ack spacing
    int        ack_cycle;               // cycle_cnt at the last ack
    int        cyc_a;
    int        n;
    setpoint_t sp_ref [`MC_NUM_MOTORS]; // last value written per motor
    wb_data_t  rd;
    wb_data_t  stamp_a;

    mc_board_top u_dut (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;  // 40 ns period
    end

    always @(posedge sysclk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // one classic cycle, held through the ack cycle, data taken while ack is high
    task automatic bus_access(input logic wr, input wb_addr_t a, input wb_data_t d,
                              output wb_data_t q);
        int waited;
        @(posedge sysclk);
        #2;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = wr;
        adr    = a;
        dat_w  = d;
        waited = 0;
        do begin
            @(posedge sysclk);
            #2;
            waited++;
        end while (!ack && waited < bus_timeout);
        if (!ack) begin
            timeout_cnt++;
            $display("no ack from address %h within %0d cycles", a, bus_timeout);
        end
        q         = dat_r;
        ack_cycle = cycle_cnt;
        @(posedge sysclk);  // host samples ack at the edge that ends the ack cycle
        #2;
        cyc       = 1'b0;  // stb low for a cycle before the next access
        stb       = 1'b0;
        we        = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t a, input wb_data_t d);
        wb_data_t unused_q;
        bus_access(1'b1, a, d, unused_q);
    endtask

    task automatic wb_read(input wb_addr_t a, output wb_data_t q);
        bus_access(1'b0, a, '0, q);
    endtask

    initial begin
        seed        = 70;
        err_cnt     = 0;
        timeout_cnt = 0;
        rst_n       = 1'b0;
        board_id    = 4'hA;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        repeat (10) @(posedge sysclk);
        #2;
        rst_n = 1'b1;

        // random setpoints, watchdog still off so dac follows
        for (int i = 0; i < `MC_NUM_MOTORS; i++) begin
            sp_ref[i] = setpoint_t'($random(seed));
            wb_write(wb_addr_t'(`MC_ADDR_SETPT + i), {16'd0, sp_ref[i]});
        end
        for (int i = 0; i < `MC_NUM_MOTORS; i++) begin
            wb_read(wb_addr_t'(`MC_ADDR_SETPT + i), rd);
            check_value($sformatf("setpoint[%0d]", i), {16'd0, sp_ref[i]}, rd);
            check_value($sformatf("dac_code[%0d]", i), {16'd0, sp_ref[i]}, {16'd0, dac_code[i]});
        end

        // amp mask, visible one cycle after the ack
        wb_write(`MC_ADDR_AMP, 32'hB);
        check_value("amp_en", 32'hB, {28'd0, amp_en});
        wb_read(`MC_ADDR_STATUS, rd);
        check_value("status amp_en", 32'hB, {28'd0, rd[19:16]});
        check_value("status board_id", {28'd0, board_id}, {28'd0, rd[3:0]});
        wb_read(8'h40, rd);  // unmapped
        check_value("unmapped dat_r", 32'd0, rd);

        // timestamp keeps running between reads
        wb_read(`MC_ADDR_STAMP, stamp_a);
        cyc_a = ack_cycle;
        repeat (5) @(posedge sysclk);
        wb_read(`MC_ADDR_STAMP, rd);
        assert (rd - stamp_a >= wb_data_t'(ack_cycle - cyc_a)) else begin
            err_cnt++;
            $display("[ERROR] %0t stamp delta expected >= %0d got %0d",
                     $time, ack_cycle - cyc_a, rd - stamp_a);
        end

        // period of 4 ticks then idle, no writes until expiry
        wb_write(`MC_ADDR_WDOG, 32'd4);
        n = 0;
        while (!wdog_timeout && n < wdog_max) begin
            @(posedge sysclk);
            #2;
            n++;
        end
        assert (wdog_timeout) else begin
            timeout_cnt++;
            $display("wdog_timeout did not rise within %0d cycles", wdog_max);
        end
        assert (n >= wdog_min) else begin
            err_cnt++;
            $display("[ERROR] %0t wdog_timeout rise cycle expected >= %0d got %0d",
                     $time, wdog_min, n);
        end
        // short period, no bit above 9 set
        check_value("wdog_period_status", 32'd1, {29'd0, wdog_period_status});
        @(posedge sysclk);
        #2;
        check_value("amp_en", 32'd0, {28'd0, amp_en});
        for (int i = 0; i < `MC_NUM_MOTORS; i++) begin
            check_value($sformatf("dac_code[%0d]", i), {16'd0, 16'(`MC_DAC_MID)},
                        {16'd0, dac_code[i]});
            wb_read(wb_addr_t'(`MC_ADDR_SETPT + i), rd);  // stored values survive
            check_value($sformatf("setpoint[%0d]", i), {16'd0, sp_ref[i]}, rd);
        end

        // clear, mask stays off until rewritten
        wb_write(`MC_ADDR_STATUS, 32'h8000_0000);
        wb_read(`MC_ADDR_STATUS, rd);
        check_value("status wdog_timeout", 32'd0, {31'd0, rd[8]});
        check_value("status period", 32'd1, {29'd0, rd[11:9]});
        check_value("amp_en", 32'd0, {28'd0, amp_en});
        wb_write(`MC_ADDR_AMP, 32'h6);
        check_value("amp_en", 32'h6, {28'd0, amp_en});
        wb_write(`MC_ADDR_WDOG, 32'd0);  // watchdog off again
        repeat (2) @(posedge sysclk);
        #2;
        check_value("wdog_period_status", 32'd0, {29'd0, wdog_period_status});

        $display("errors: %0d value, %0d timeout, %0d assertion",
                 err_cnt, timeout_cnt, u_dut.u_chk.fail_cnt);
        if (err_cnt + timeout_cnt + u_dut.u_chk.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* mc_board_chk.sv */
// bus handshake and safe-state assertions, bound into every board top level instance
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_board_chk (
    input logic                                          sysclk,
    input logic                                          rst_n,
    input logic                                          cyc,
    input logic                                          stb,
    input logic                                          ack,
    input logic                                          wdog_timeout,
    input mc_motor_pkg::amp_mask_t                       amp_en,
    input mc_motor_pkg::setpoint_t [`MC_NUM_MOTORS-1:0]  dac_code
);

    import mc_motor_pkg::*;

    localparam setpoint_t [`MC_NUM_MOTORS-1:0] mid_codes =
        {`MC_NUM_MOTORS{setpoint_t'(`MC_DAC_MID)}};  // zero current everywhere

    int fail_cnt = 0;  // failed checks so far

    ack_one_cycle: assert property (@(posedge sysclk) disable iff (!rst_n) ack |=> !ack)
        else begin
            fail_cnt++;
            $error("ack stayed high for two cycles");
        end

    // ack only answers a request seen one edge before
    ack_after_req: assert property (@(posedge sysclk) disable iff (!rst_n)
        ack |-> $past(cyc && stb))
        else begin
            fail_cnt++;
            $error("ack without cyc and stb in the previous cycle");
        end

    amp_off_on_timeout: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_timeout |=> (amp_en == '0))
        else begin
            fail_cnt++;
            $error("amplifiers still enabled after watchdog timeout");
        end

    dac_mid_on_timeout: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_timeout |=> (dac_code == mid_codes))
        else begin
            fail_cnt++;
            $error("dac codes not at midscale after watchdog timeout");
        end

endmodule

bind mc_board_top mc_board_chk u_chk (
    .sysclk(sysclk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .ack(ack),
    .wdog_timeout(wdog_timeout), .amp_en(amp_en), .dac_code(dac_code)
);

/* mc_board_top.sv */
// board top level, ties the bus controller, watchdog and motor bank to the board pins
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_board_top (
    input  logic                                          sysclk,
    input  logic                                          rst_n,
    input  mc_bus_pkg::board_id_t                         board_id,
    input  logic                                          cyc,
    input  logic                                          stb,
    input  logic                                          we,
    input  mc_bus_pkg::wb_addr_t                          adr,
    input  mc_bus_pkg::wb_data_t                          dat_w,
    output mc_bus_pkg::wb_data_t                          dat_r,
    output logic                                          ack,
    output mc_motor_pkg::amp_mask_t                       amp_en,
    output mc_motor_pkg::setpoint_t [`MC_NUM_MOTORS-1:0]  dac_code,
    output logic                                          wdog_timeout,
    output logic [2:0]                                    wdog_period_status
);

    import mc_motor_pkg::*;

    logic                             wdog_kick;
    logic                             wdog_clear;
    logic                             period_we;
    wdog_period_t                     period_wdata;
    logic                             sp_we;
    logic [1:0]                       sp_idx;
    setpoint_t                        sp_wdata;
    logic                             amp_we;
    amp_mask_t                        amp_wdata;
    setpoint_t [`MC_NUM_MOTORS-1:0]   sp_rdata_all;  // readback for the read mux

    mc_reg_ctrl u_reg_ctrl (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .wdog_timeout(wdog_timeout), .wdog_period_status(wdog_period_status),
        .wdog_kick(wdog_kick), .wdog_clear(wdog_clear),
        .period_we(period_we), .period_wdata(period_wdata),
        .amp_en(amp_en), .sp_rdata_all(sp_rdata_all),
        .sp_we(sp_we), .sp_idx(sp_idx), .sp_wdata(sp_wdata),
        .amp_we(amp_we), .amp_wdata(amp_wdata)
    );

    mc_watchdog u_watchdog (
        .sysclk(sysclk), .rst_n(rst_n),
        .wdog_kick(wdog_kick), .wdog_clear(wdog_clear),
        .period_we(period_we), .period_wdata(period_wdata),
        .wdog_timeout(wdog_timeout), .wdog_period_status(wdog_period_status)
    );

    mc_motor_bank #(.num_motors(`MC_NUM_MOTORS)) u_motor_bank (
        .sysclk(sysclk), .rst_n(rst_n),
        .sp_we(sp_we), .sp_idx(sp_idx), .sp_wdata(sp_wdata),
        .amp_we(amp_we), .amp_wdata(amp_wdata), .wdog_timeout(wdog_timeout),
        .amp_en(amp_en), .dac_code(dac_code), .sp_rdata_all(sp_rdata_all)
    );

endmodule

/* mc_motor_bank.sv */
// per-motor current setpoints and amplifier enables, forced to a safe state on watchdog timeout
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_motor_bank #(
    parameter int num_motors = `MC_NUM_MOTORS
) (
    input  logic                                       sysclk,
    input  logic                                       rst_n,
    input  logic                                       sp_we,
    input  logic [1:0]                                 sp_idx,
    input  mc_motor_pkg::setpoint_t                    sp_wdata,
    input  logic                                       amp_we,
    input  mc_motor_pkg::amp_mask_t                    amp_wdata,
    input  logic                                       wdog_timeout,
    output mc_motor_pkg::amp_mask_t                    amp_en,
    output mc_motor_pkg::setpoint_t [num_motors-1:0]   dac_code,
    output mc_motor_pkg::setpoint_t [num_motors-1:0]   sp_rdata_all
);

    import mc_motor_pkg::*;

    // zero current on every channel
    localparam setpoint_t [num_motors-1:0] safe_codes = {num_motors{setpoint_t'(`MC_DAC_MID)}};
    // bits for motors that exist
    localparam amp_mask_t valid_mask = amp_mask_t'((1 << num_motors) - 1);

    setpoint_t [num_motors-1:0] sp_q;     // stored setpoints, kept through a timeout
    setpoint_t [num_motors-1:0] sp_next;
    amp_mask_t                  mask_q;

    always_comb begin
        sp_next = sp_q;
        if (sp_we && (int'(sp_idx) < num_motors)) begin
            sp_next[sp_idx] = sp_wdata;
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            sp_q     <= safe_codes;  // dac follows sp_q, so start at midscale
            mask_q   <= '0;
            dac_code <= safe_codes;
        end else begin
            sp_q <= sp_next;
            if (wdog_timeout) begin
                mask_q   <= '0;           // host must re-enable after clear
                dac_code <= safe_codes;
            end else begin
                if (amp_we) begin
                    mask_q <= amp_wdata & valid_mask;
                end
                dac_code <= sp_next;      // same edge as the stored value
            end
        end
    end

    assign amp_en       = mask_q;
    assign sp_rdata_all = sp_q;

endmodule

/* mc_watchdog.sv */
// host watchdog, prescaled tick counter that flags a timeout when no write arrives within the period
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_watchdog (
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  logic                        wdog_kick,     // any host write
    input  logic                        wdog_clear,
    input  logic                        period_we,
    input  mc_motor_pkg::wdog_period_t  period_wdata,
    output logic                        wdog_timeout,
    output logic [2:0]                  wdog_period_status
);

    import mc_motor_pkg::*;

    localparam int div_w = $clog2(`MC_WDOG_TICK_DIV);

    logic [div_w-1:0] pre_cnt;   // free running, phase not tied to kicks
    logic             tick;
    wdog_period_t     period;
    wdog_period_t     tick_cnt;  // whole ticks since last kick
    wdog_state_e      state;

    assign tick = (pre_cnt == div_w'(`MC_WDOG_TICK_DIV - 1));

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
        end
    end

    // first partial tick after a kick is not counted, so expiry lands at P+1 ticks
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= WDOG_OFF;
            tick_cnt <= '0;
            period   <= '0;  // off out of reset
        end else begin
            if (period_we) begin
                period <= period_wdata;
            end
            case (state)
                WDOG_OFF: begin
                    tick_cnt <= '0;
                    if (period != '0) state <= WDOG_ARMED;
                end
                WDOG_ARMED: begin
                    if (period == '0) begin
                        state <= WDOG_OFF;
                    end else if (wdog_kick) begin
                        tick_cnt <= '0;
                    end else if (tick) begin
                        if (tick_cnt >= period) state <= WDOG_EXPIRED;  // >= covers a shrunk period
                        else tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                WDOG_EXPIRED: begin
                    if (wdog_clear) begin  // only way out
                        state    <= WDOG_ARMED;
                        tick_cnt <= '0;
                    end
                end
                default: state <= WDOG_OFF;
            endcase
        end
    end

    assign wdog_timeout = (state == WDOG_EXPIRED);

    // led code: 0 off, 1 short period, 2..7 for top bit 10..15
    always_comb begin
        wdog_period_status = '0;
        if (period != '0) wdog_period_status = 3'd1;
        for (int b = 10; b <= 15; b++) begin
            if (period[b]) wdog_period_status = 3'(b - 8);
        end
    end

endmodule

/* mc_reg_ctrl.sv */
// wishbone slave with address decode, board status, timestamp and write strobes to the datapath
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mc_reg_ctrl (
    input  logic                                          sysclk,
    input  logic                                          rst_n,
    input  mc_bus_pkg::board_id_t                         board_id,
    // wishbone classic slave
    input  logic                                          cyc,
    input  logic                                          stb,
    input  logic                                          we,
    input  mc_bus_pkg::wb_addr_t                          adr,
    input  mc_bus_pkg::wb_data_t                          dat_w,
    output mc_bus_pkg::wb_data_t                          dat_r,
    output logic                                          ack,
    // watchdog side
    input  logic                                          wdog_timeout,
    input  logic [2:0]                                    wdog_period_status,
    output logic                                          wdog_kick,
    output logic                                          wdog_clear,
    output logic                                          period_we,
    output mc_motor_pkg::wdog_period_t                    period_wdata,
    // motor bank side
    input  mc_motor_pkg::amp_mask_t                       amp_en,
    input  mc_motor_pkg::setpoint_t [`MC_NUM_MOTORS-1:0]  sp_rdata_all,
    output logic                                          sp_we,
    output logic [1:0]                                    sp_idx,
    output mc_motor_pkg::setpoint_t                       sp_wdata,
    output logic                                          amp_we,
    output mc_motor_pkg::amp_mask_t                       amp_wdata
);

    import mc_bus_pkg::*;
    import mc_motor_pkg::*;

    logic         req;          // first cycle of a new access
    logic         wr_req;
    logic         hit_setpt;    // address falls in the setpoint window
    wb_addr_t     sp_off;       // offset into setpoint window
    wb_data_t     status_word;
    wb_data_t     rd_mux;
    stamp_t       stamp;
    wdog_period_t period_copy;  // readback copy, watchdog keeps its own

    // ack goes out one cycle after cyc&stb, never twice in a row
    assign req    = cyc & stb & ~ack;
    assign wr_req = req & we;

    assign sp_off    = adr - `MC_ADDR_SETPT;
    assign hit_setpt = (adr >= `MC_ADDR_SETPT) && (sp_off < `MC_NUM_MOTORS);

    always_comb begin
        status_word = '0;
        status_word[stat_id_msb:stat_id_lsb]   = board_id;
        status_word[stat_wdog_bit]             = wdog_timeout;
        status_word[stat_per_msb:stat_per_lsb] = wdog_period_status;
        status_word[stat_amp_lsb +: `MC_NUM_MOTORS] = amp_en;  // upper bits stay 0
    end

    // read mux, unmapped reads give zero
    always_comb begin
        rd_mux = '0;
        case (adr)
            `MC_ADDR_STATUS: rd_mux = status_word;
            `MC_ADDR_STAMP:  rd_mux = stamp;
            `MC_ADDR_WDOG:   rd_mux = {16'd0, period_copy};
            `MC_ADDR_AMP:    rd_mux[`MC_NUM_MOTORS-1:0] = amp_en;
            default: begin
                if (hit_setpt) begin
                    rd_mux = {16'd0, sp_rdata_all[sp_off[1:0]]};
                end
            end
        endcase
    end

    // handshake and one-shot strobes, all high during the ack cycle
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            wdog_kick  <= 1'b0;
            wdog_clear <= 1'b0;
            period_we  <= 1'b0;
            sp_we      <= 1'b0;
            amp_we     <= 1'b0;
        end else begin
            ack        <= req;
            wdog_kick  <= wr_req;  // any write counts as host activity
            wdog_clear <= wr_req && (adr == `MC_ADDR_STATUS) && dat_w[stat_clr_bit];
            period_we  <= wr_req && (adr == `MC_ADDR_WDOG);
            sp_we      <= wr_req && hit_setpt;
            amp_we     <= wr_req && (adr == `MC_ADDR_AMP);
        end
    end

    // payload captured with the strobes, host may drop dat_w after ack
    always_ff @(posedge sysclk) begin
        if (req) begin
            dat_r <= rd_mux;  // sampled at the ack edge
        end
        if (wr_req) begin
            sp_idx       <= sp_off[1:0];
            sp_wdata     <= dat_w[15:0];
            amp_wdata    <= dat_w[`MC_NUM_MOTORS-1:0];
            period_wdata <= dat_w[15:0];
        end
    end

    // timestamp restarts the cycle after each acked write
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            stamp       <= '0;
            period_copy <= '0;
        end else begin
            stamp <= wdog_kick ? '0 : stamp + 1'b1;
            if (period_we) begin
                period_copy <= period_wdata;
            end
        end
    end

endmodule

/* mc_motor_pkg.sv */
// motor setpoint, amplifier mask and watchdog types shared by the motor-side RTL
`include "mc_cfg.svh"

package mc_motor_pkg;

    typedef logic [15:0] setpoint_t;                 // unsigned dac code
    typedef logic [`MC_NUM_MOTORS-1:0] amp_mask_t;   // one enable per motor

    // period in prescaled ticks, zero turns the watchdog off
    typedef logic [15:0] wdog_period_t;

    // watchdog fsm
    typedef enum logic [1:0] {
        WDOG_OFF     = 2'd0,  // period is zero
        WDOG_ARMED   = 2'd1,  // counting ticks since last kick
        WDOG_EXPIRED = 2'd2   // timed out, waits for clear
    } wdog_state_e;

    // all status codes fit in 3 bits
    localparam int wdog_status_w = 3;

endpackage

/* mc_bus_pkg.sv */
// host bus widths, register-map types and status word bit positions, imported by the bus-side RTL
package mc_bus_pkg;

    typedef logic [7:0]  wb_addr_t;   // register word address
    typedef logic [31:0] wb_data_t;   // wishbone data word
    typedef logic [3:0]  board_id_t;  // rotary switch value
    typedef logic [31:0] stamp_t;     // free-running cycle count

    // status register layout
    localparam int stat_id_lsb   = 0;   // board id field
    localparam int stat_id_msb   = 3;
    localparam int stat_wdog_bit = 8;   // watchdog timed out
    localparam int stat_per_lsb  = 9;   // coarse period, led code
    localparam int stat_per_msb  = 11;
    localparam int stat_amp_lsb  = 16;  // amplifier enables, one per motor
    localparam int stat_amp_msb  = 19;

    // write side only, reads back as zero
    localparam int stat_clr_bit  = 31;  // write 1 to clear the timeout

endpackage

/* mc_cfg.svh */
// board build constants, included by every file that needs motor count, timing or addresses
`ifndef MC_CFG_SVH
`define MC_CFG_SVH

`define MC_NUM_MOTORS     4        // motors on the board, status field allows up to 4
`define MC_WDOG_TICK_DIV  16       // sysclk cycles per watchdog tick, short for sim
`define MC_DAC_MID        16'h8000 // zero current code

// register word addresses
`define MC_ADDR_STATUS    8'h00
`define MC_ADDR_STAMP     8'h01
`define MC_ADDR_WDOG      8'h02
`define MC_ADDR_AMP       8'h03
`define MC_ADDR_SETPT     8'h10    // motor n at base + n

`endif
